// ==== Bender.yml ====
package:
  name: adc_sync_ctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - adc_sync_pkg.sv
      - sample_if.sv
      - sync_delay_timer.sv
      - clock_phase_sampler.sv
      - adc_reset_pulse.sv
      - adc_sync_fsm.sv
      - adc_sync_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_adc_sync_ctrl.sv

// ==== adc_reset_pulse.sv ====
`timescale 1ns/1ps
`include "sync_consts.svh"

module adc_reset_pulse (
	input  logic dcm_psclk,
	input  logic ctrl_reset,
	input  logic reset_start,
	output logic adc1_reset,
	output adc_sync_pkg::reset_phase_t reset_phase
);

	localparam int PULSE_W = $clog2(`SYNC_RESET_CYCLES + 1);

	adc_sync_pkg::reset_phase_t phase_cnt; // Phase for the next attempt
	logic [PULSE_W-1:0] pulse_cnt;         // Remaining pulse cycles

	// ==============================
	// Phase rotation
	// ==============================
	// Each attempt moves to the next ADC0 phase, 0 -> 90 -> 180 -> 270 -> 0
	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset) begin
			phase_cnt <= '0;
			reset_phase <= '0;
		end else if (reset_start) begin
			reset_phase <= phase_cnt;
			phase_cnt <= phase_cnt + 1'b1; // Wraps after 270 deg
		end
	end

	// ==============================
	// Pulse length
	// ==============================
	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset) begin
			pulse_cnt <= '0;
		end else if (reset_start) begin
			pulse_cnt <= PULSE_W'(`SYNC_RESET_CYCLES);
		end else if (pulse_cnt != '0) begin
			pulse_cnt <= pulse_cnt - 1'b1;
		end
	end

	// High from the cycle after the start, for the full count
	assign adc1_reset = (pulse_cnt != '0);

endmodule

// ==== adc_sync_ctrl.sv ====
`timescale 1ns/1ps

module adc_sync_ctrl (
	input  logic dcm_psclk,
	input  logic ctrl_reset,
	input  logic adc0_dcm_locked,
	input  logic adc1_dcm_locked,
	input  logic [3:0] phase_levels, // ADC1 clock seen at 0/90/180/270 deg
	output logic adc1_reset,
	output logic [1:0] reset_phase,
	output logic sync_done
);

	// ==============================
	// Internal wiring
	// ==============================
	logic timer_clear;
	logic init_elapsed;
	logic wait_elapsed;
	logic reset_start;

	sample_if smp ();

	// ==============================
	// Delay timer
	// ==============================
	sync_delay_timer i_timer (
		.dcm_psclk    (dcm_psclk),
		.ctrl_reset   (ctrl_reset),
		.timer_clear  (timer_clear),
		.init_elapsed (init_elapsed),
		.wait_elapsed (wait_elapsed)
	);

	// Phase level sampling
	clock_phase_sampler i_sampler (
		.dcm_psclk    (dcm_psclk),
		.ctrl_reset   (ctrl_reset),
		.phase_levels (phase_levels),
		.smp          (smp.sampler)
	);

	// ==============================
	// ADC1 reset generation
	// ==============================
	adc_reset_pulse i_reset_pulse (
		.dcm_psclk   (dcm_psclk),
		.ctrl_reset  (ctrl_reset),
		.reset_start (reset_start),
		.adc1_reset  (adc1_reset),
		.reset_phase (reset_phase)
	);

	// ==============================
	// Sequencing
	// ==============================
	adc_sync_fsm i_fsm (
		.dcm_psclk       (dcm_psclk),
		.ctrl_reset      (ctrl_reset),
		.init_elapsed    (init_elapsed),
		.wait_elapsed    (wait_elapsed),
		.adc0_dcm_locked (adc0_dcm_locked),
		.adc1_dcm_locked (adc1_dcm_locked),
		.smp             (smp.fsm),
		.timer_clear     (timer_clear),
		.reset_start     (reset_start),
		.sync_done       (sync_done)
	);

endmodule

// ==== adc_sync_fsm.sv ====
`timescale 1ns/1ps

module adc_sync_fsm (
	input  logic dcm_psclk,
	input  logic ctrl_reset,
	input  logic init_elapsed,
	input  logic wait_elapsed,
	input  logic adc0_dcm_locked,
	input  logic adc1_dcm_locked,
	sample_if.fsm smp,
	output logic timer_clear,
	output logic reset_start,
	output logic sync_done
);

	adc_sync_pkg::sync_state_t state;
	adc_sync_pkg::sync_state_t next_state;

	logic dcm_locked;
	logic phase_ok;

	assign dcm_locked = adc0_dcm_locked && adc1_dcm_locked;

	// ADC1 clock high at both 90 and 180 deg means a good phase
	assign phase_ok = smp.sample_levels[1] && smp.sample_levels[2];

	// ==============================
	// State register
	// ==============================
	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset) begin
			state <= adc_sync_pkg::init;
		end else begin
			state <= next_state;
		end
	end

	// ==============================
	// Next state and outputs
	// ==============================
	always_comb begin
		next_state = state;
		timer_clear = 1'b0;
		reset_start = 1'b0;
		smp.sample_req = 1'b0;
		sync_done = 1'b0;

		case (state)
			adc_sync_pkg::init: begin
				if (init_elapsed) begin
					next_state = adc_sync_pkg::reset_adc;
				end
			end

			// One cycle only
			adc_sync_pkg::reset_adc: begin
				timer_clear = 1'b1; // Settle time starts here
				reset_start = 1'b1;
				next_state = adc_sync_pkg::wait_adc;
			end

			adc_sync_pkg::wait_adc: begin
				if (wait_elapsed) begin
					next_state = adc_sync_pkg::wait_dcm;
				end
			end

			adc_sync_pkg::wait_dcm: begin
				if (dcm_locked) begin
					next_state = adc_sync_pkg::sample_clocks;
				end
			end

			adc_sync_pkg::sample_clocks: begin
				smp.sample_req = 1'b1;
				if (smp.sample_error) begin
					next_state = adc_sync_pkg::reset_adc; // Unreliable, try next phase
				end else if (smp.sample_valid) begin
					next_state = adc_sync_pkg::decide;
				end
			end

			adc_sync_pkg::decide: begin
				timer_clear = 1'b1;
				if (phase_ok) begin
					next_state = adc_sync_pkg::done;
				end else begin
					next_state = adc_sync_pkg::reset_adc;
				end
			end

			adc_sync_pkg::done: begin
				sync_done = 1'b1; // Held until ctrl_reset
			end

			default: begin
				next_state = adc_sync_pkg::reset_adc;
			end
		endcase
	end

endmodule

// ==== adc_sync_pkg.sv ====
`include "sync_consts.svh"

package adc_sync_pkg;

	// Synchronization sequence
	typedef enum logic [2:0] {
		init,          // Power-up delay
		reset_adc,     // Fire one ADC1 reset
		wait_adc,      // ADC settle time
		wait_dcm,      // Both clock managers locked
		sample_clocks, // Sample ADC1 clock at four ADC0 phases
		decide,
		done
	} sync_state_t;

	// ADC1 clock level per ADC0 phase
	// bit 0 = 0 deg, bit 1 = 90, bit 2 = 180, bit 3 = 270
	typedef logic [3:0] phase_levels_t;

	typedef logic [1:0] reset_phase_t; // ADC0 phase index of a reset

	typedef logic [`SYNC_TIMER_WIDTH-1:0] sync_timer_t;

endpackage

// ==== clock_phase_sampler.sv ====
`timescale 1ns/1ps
`include "sync_consts.svh"

module clock_phase_sampler (
	input  logic dcm_psclk,
	input  logic ctrl_reset,
	input  adc_sync_pkg::phase_levels_t phase_levels,
	sample_if.sampler smp
);

	localparam int STABLE_W = $clog2(`SYNC_SAMPLE_STABLE + 1);
	localparam int CHANGE_W = $clog2(`SYNC_SAMPLE_MAX_CHANGES + 1);

	adc_sync_pkg::phase_levels_t last_levels; // Previous reading
	logic primed;                             // last_levels holds a real reading
	logic [STABLE_W-1:0] stable_cnt;
	logic [CHANGE_W-1:0] change_cnt;

	logic sampling;
	logic same_level;
	logic stable_hit;
	logic change_hit;

	// Stop once a verdict is out, until the request drops
	assign sampling = smp.sample_req && !smp.sample_valid && !smp.sample_error;
	assign same_level = primed && (phase_levels == last_levels);

	// Reading that completes the stable run
	assign stable_hit = same_level &&
		(stable_cnt == STABLE_W'(`SYNC_SAMPLE_STABLE - 1));

	// Reading that hits the change limit
	assign change_hit = primed && !same_level &&
		(change_cnt == CHANGE_W'(`SYNC_SAMPLE_MAX_CHANGES - 1));

	// ==============================
	// Sampling control
	// ==============================
	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset || !smp.sample_req) begin
			primed <= 1'b0;
			stable_cnt <= '0;
			change_cnt <= '0;
			smp.sample_valid <= 1'b0;
			smp.sample_error <= 1'b0;
		end else if (sampling) begin
			primed <= 1'b1; // First reading only loads last_levels
			if (same_level) begin
				stable_cnt <= stable_cnt + 1'b1;
				smp.sample_valid <= stable_hit;
			end else if (primed) begin
				stable_cnt <= '0; // Level moved, start the run again
				change_cnt <= change_cnt + 1'b1;
				smp.sample_error <= change_hit;
			end
		end
	end

	// Reading history and result levels
	always_ff @(posedge dcm_psclk) begin
		if (sampling) begin
			last_levels <= phase_levels;
			if (stable_hit) begin
				smp.sample_levels <= phase_levels; // Kept for the decide step
			end
		end
	end

endmodule

// ==== sample_if.sv ====
`timescale 1ns/1ps

// Link between the sync FSM and the clock phase sampler
interface sample_if;

	logic sample_req;   // Held high through the whole sampling state
	logic sample_valid; // Levels stable, held until request drops
	logic sample_error; // Too many level changes
	adc_sync_pkg::phase_levels_t sample_levels;

	modport fsm (
		output sample_req,
		input  sample_valid,
		input  sample_error,
		input  sample_levels
	);

	modport sampler (
		input  sample_req,
		output sample_valid,
		output sample_error,
		output sample_levels
	);

endinterface

// ==== sync_consts.svh ====
`ifndef SYNC_CONSTS_SVH
`define SYNC_CONSTS_SVH

// ==============================
// Start-up delays
// ==============================
`define SYNC_INIT_DELAY 200 // Power-up wait, scaled down for simulation
`define SYNC_ADC_WAIT 40 // ADC settle time after a reset pulse

// Width of the shared delay timer
`define SYNC_TIMER_WIDTH 16

// ==============================
// ADC1 reset pulse
// ==============================
`define SYNC_RESET_CYCLES 8 // Pulse length in dcm_psclk cycles

// Clock phase sampler limits
`define SYNC_SAMPLE_STABLE 4 // Equal readings in a row for a valid sample
`define SYNC_SAMPLE_MAX_CHANGES 3 // Reading changes before giving up

`endif

// ==== sync_delay_timer.sv ====
`timescale 1ns/1ps
`include "sync_consts.svh"

module sync_delay_timer (
	input  logic dcm_psclk,
	input  logic ctrl_reset,
	input  logic timer_clear,
	output logic init_elapsed,
	output logic wait_elapsed
);

	adc_sync_pkg::sync_timer_t count;

	// ==============================
	// Free-running counter
	// ==============================
	// Counts up from reset or clear and sticks at all ones
	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset) begin
			count <= '0;
		end else if (timer_clear) begin
			count <= '0;
		end else if (count != '1) begin
			count <= count + 1'b1;
		end
	end

	// ==============================
	// Delay flags
	// ==============================
	// Power-up delay before the first ADC reset
	assign init_elapsed = (count > adc_sync_pkg::sync_timer_t'(`SYNC_INIT_DELAY));

	assign wait_elapsed = (count > adc_sync_pkg::sync_timer_t'(`SYNC_ADC_WAIT)); // ADC settle

endmodule

// ==== tb_adc_sync_ctrl.sv ====
`timescale 1ns/1ps
`include "sync_consts.svh"

module tb_adc_sync_ctrl;

	localparam int NUM_ROWS = 5;
	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;     // Input drive point after the rising edge
	localparam int RESET_CYCLES = 16;
	localparam int DONE_HOLD = 100;     // Cycles watched after sync_done
	localparam int ATTEMPT_LIMIT = 200; // Lock return to next pulse or done
	localparam int LOCK_JITTER = 16;
	localparam int LOCK_STAGGER = 48;   // Cycles with only one clock manager locked

	// One ADC1 reset attempt
	typedef struct packed {
		adc_sync_pkg::phase_levels_t pattern;
		logic noisy;          // Toggle the pattern every cycle
		logic [7:0] lock_dly; // Cycles from pulse end to the first lock
	} attempt_t;

	attempt_t stim [NUM_ROWS][4];
	int unsigned exp_attempts [NUM_ROWS];

	logic dcm_psclk = 1'b0;
	logic ctrl_reset;
	logic adc0_dcm_locked;
	logic adc1_dcm_locked;
	adc_sync_pkg::phase_levels_t phase_levels;
	logic adc1_reset;
	adc_sync_pkg::reset_phase_t reset_phase;
	logic sync_done;

	int unsigned errors = 0;
	int unsigned checks = 0;
	int unsigned rows_failed = 0;
	int seed_val;

	adc_sync_ctrl i_dut (
		.dcm_psclk       (dcm_psclk),
		.ctrl_reset      (ctrl_reset),
		.adc0_dcm_locked (adc0_dcm_locked),
		.adc1_dcm_locked (adc1_dcm_locked),
		.phase_levels    (phase_levels),
		.adc1_reset      (adc1_reset),
		.reset_phase     (reset_phase),
		.sync_done       (sync_done)
	);

	always #(CLK_PERIOD / 2) dcm_psclk = ~dcm_psclk;

	// ==============================
	// Helpers
	// ==============================
	task automatic tick();
		@(posedge dcm_psclk);
		#(DRIVE_DELAY);
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_phase(input string name, input adc_sync_pkg::reset_phase_t got,
		input adc_sync_pkg::reset_phase_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_count(input string name, input adc_sync_pkg::sync_timer_t got,
		input adc_sync_pkg::sync_timer_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// No pulse and no sync_done for n cycles
	task automatic expect_idle(input int unsigned n);
		repeat (n) begin
			tick();
			check_flag("adc1_reset", adc1_reset, 1'b0);
			check_flag("sync_done", sync_done, 1'b0);
		end
	endtask

	task automatic set_attempt(input int row, input int idx,
		input adc_sync_pkg::phase_levels_t pattern, input logic noisy, input int dly);
		stim[row][idx].pattern = pattern;
		stim[row][idx].noisy = noisy;
		stim[row][idx].lock_dly = dly[7:0];
	endtask

	// ==============================
	// Stimulus table
	// ==============================
	task automatic load_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int i = 0; i < 4; i++) begin
				stim[r][i] = '0;
			end
		end
		set_attempt(0, 0, 4'b0110, 1'b0, 0);   // Good phase at once
		exp_attempts[0] = 1;
		set_attempt(1, 0, 4'b0010, 1'b0, 10);  // 180 deg low
		set_attempt(1, 1, 4'b1110, 1'b0, 60);
		exp_attempts[1] = 2;
		set_attempt(2, 0, 4'b0110, 1'b1, 20);  // Sampler error path
		set_attempt(2, 1, 4'b0111, 1'b0, 5);
		exp_attempts[2] = 2;
		set_attempt(3, 0, 4'b0100, 1'b0, 100); // Full phase rotation
		set_attempt(3, 1, 4'b0000, 1'b0, 50);
		set_attempt(3, 2, 4'b1001, 1'b0, 0);
		set_attempt(3, 3, 4'b0110, 1'b0, 70);
		exp_attempts[3] = 4;
		set_attempt(4, 0, 4'b0110, 1'b1, 40);
		set_attempt(4, 1, 4'b0011, 1'b0, 0);
		set_attempt(4, 2, 4'b1110, 1'b0, 80);
		exp_attempts[4] = 3;
	endtask

	// Worst-case run length in cycles
	function automatic longint unsigned watchdog_cycles();
		longint unsigned total;
		longint unsigned max_lock;
		max_lock = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int i = 0; i < 4; i++) begin
				if (stim[r][i].lock_dly > max_lock) max_lock = stim[r][i].lock_dly;
			end
		end
		max_lock += LOCK_JITTER + LOCK_STAGGER;
		total = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			total += RESET_CYCLES + DONE_HOLD;
			total += exp_attempts[r] * (`SYNC_INIT_DELAY + `SYNC_ADC_WAIT + max_lock + 64);
		end
		return total + 500; // Margin
	endfunction

	// ==============================
	// One table row
	// ==============================
	task automatic run_row(input int row);
		int unsigned cycles;
		int unsigned lock_cycles;
		int unsigned attempts;
		int unsigned errors_before;
		adc_sync_pkg::phase_levels_t mask;
		logic expect_good;
		logic finished;
		errors_before = errors;
		attempts = 0;
		finished = 1'b0;
		ctrl_reset = 1'b1;
		adc0_dcm_locked = 1'b0;
		adc1_dcm_locked = 1'b0;
		phase_levels = '0;
		repeat (RESET_CYCLES) tick();
		ctrl_reset = 1'b0;

		// Nothing may happen during the power-up delay
		cycles = 0;
		while (!adc1_reset && cycles <= `SYNC_INIT_DELAY + 20) begin
			tick();
			cycles++;
			check_flag("sync_done", sync_done, 1'b0);
		end
		if (!adc1_reset) begin
			errors++;
			$display("row %0d: no adc1_reset pulse after the power-up delay", row);
			finished = 1'b1;
		end else if (cycles <= `SYNC_INIT_DELAY) begin
			errors++;
			$display("row %0d: adc1_reset rose after only %0d cycles", row, cycles);
		end

		for (int a = 0; a < 4 && !finished; a++) begin
			attempts++;
			check_phase("reset_phase", reset_phase, adc_sync_pkg::reset_phase_t'(a % 4));
			expect_good = !stim[row][a].noisy && stim[row][a].pattern[1] &&
				stim[row][a].pattern[2];
			mask = adc_sync_pkg::phase_levels_t'($urandom % 15 + 1); // Noise positions
			lock_cycles = stim[row][a].lock_dly + $urandom % LOCK_JITTER;
			adc0_dcm_locked = 1'b0; // ADC reset drops both locks
			adc1_dcm_locked = 1'b0;
			phase_levels = stim[row][a].pattern;

			cycles = 0;
			while (adc1_reset && cycles < 64) begin
				tick();
				cycles++;
				check_flag("sync_done", sync_done, 1'b0);
			end
			check_count("adc1_reset pulse length", adc_sync_pkg::sync_timer_t'(cycles),
				adc_sync_pkg::sync_timer_t'(`SYNC_RESET_CYCLES));

			expect_idle(lock_cycles);

			// One clock manager locks well before the other
			if ((row + a) % 2 == 0) begin
				adc0_dcm_locked = 1'b1;
			end else begin
				adc1_dcm_locked = 1'b1;
			end
			expect_idle(LOCK_STAGGER);
			adc0_dcm_locked = 1'b1;
			adc1_dcm_locked = 1'b1;

			// Sampling then decide or retry
			cycles = 0;
			while (!adc1_reset && !sync_done && cycles < ATTEMPT_LIMIT) begin
				tick();
				cycles++;
				if (stim[row][a].noisy) phase_levels = phase_levels ^ mask;
			end

			if (!adc1_reset && !sync_done) begin
				errors++;
				$display("row %0d: attempt %0d got neither a new pulse nor sync_done", row, a);
				finished = 1'b1;
			end else if (expect_good) begin
				check_flag("sync_done", sync_done, 1'b1);
				check_flag("adc1_reset", adc1_reset, 1'b0);
				repeat (DONE_HOLD) begin
					tick();
					check_flag("adc1_reset", adc1_reset, 1'b0);
					check_flag("sync_done", sync_done, 1'b1);
				end
				finished = 1'b1;
			end else begin
				check_flag("sync_done", sync_done, 1'b0);
				check_flag("adc1_reset", adc1_reset, 1'b1);
			end
		end

		check_count("attempts", adc_sync_pkg::sync_timer_t'(attempts),
			adc_sync_pkg::sync_timer_t'(exp_attempts[row]));
		if (errors == errors_before) begin
			$display("row %0d passed after %0d attempts", row, attempts);
		end else begin
			rows_failed++;
			$display("row %0d failed with %0d errors", row, errors - errors_before);
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		seed_val = $urandom(32'hcb385c77);
		ctrl_reset = 1'b1;
		adc0_dcm_locked = 1'b0;
		adc1_dcm_locked = 1'b0;
		phase_levels = '0;
		load_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		$display("rows %0d, failed %0d, checks %0d, errors %0d",
			NUM_ROWS, rows_failed, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		longint unsigned limit;
		#1;
		limit = watchdog_cycles();
		#(limit * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
adc_sync_pkg.sv
sample_if.sv
sync_delay_timer.sv
clock_phase_sampler.sv
adc_reset_pulse.sv
adc_sync_fsm.sv
adc_sync_ctrl.sv
tb_adc_sync_ctrl.sv
